// ==== build.f ====
common/memBusPkg.sv
common/memCtrlPkg.sv
common/stepIf.sv
memctrl/byteCounter.sv
memctrl/byteDatapath.sv
memctrl/accessSequencer.sv
hw/memCtrlTop.sv
tb/byteRamModel.sv
tb/memCtrl_assertions.sv
tb/memCtrlTb.sv

// ==== common/memBusPkg.sv ====
package memBusPkg;

    // word geometry
    localparam int wordBytes = 4;
    localparam int byteWidth = 8;
    localparam int wordWidth = wordBytes * byteWidth;
    localparam int addrWidth = 32;

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [byteWidth-1:0] byteT;
    typedef logic [addrWidth-1:0] addrT;

    // lane inside a word
    typedef logic [$clog2(wordBytes)-1:0] byteIdxT;

    // transfer length in bytes, 1, 2 or 4
    typedef logic [2:0] lenT;

    // instruction fetch always pulls a whole word
    localparam lenT fetchBytes = lenT'(wordBytes);

endpackage

// ==== common/memCtrlPkg.sv ====
package memCtrlPkg;

    // one transfer walks Idle -> Issue -> (Drain) -> Done
    typedef enum logic [1:0] {
        Idle,
        Issue,
        Drain,
        Done
    } seqStateT;

    typedef enum logic [1:0] {
        Fetch,
        Load,
        Store
    } accessKindT;

endpackage

// ==== common/stepIf.sv ====
interface stepIf;
    import memBusPkg::*;

    // sequencer side
    logic start;
    lenT length;
    logic advance;

    // counter side
    byteIdxT byteIdx;
    logic last;

    modport sequencer (output start, output length, output advance, input last);

    modport counter (input start, input length, input advance, output byteIdx, output last);

    modport datapath (input byteIdx);

endinterface

// ==== hw/memCtrlTop.sv ====
module memCtrlTop #(
    parameter int ramAddrWidth = 17
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    i_ifEn,
    input  memBusPkg::addrT         i_ifAddr,
    output logic                    o_ifDone,
    output memBusPkg::wordT         o_ifInst,

    input  logic                    i_dcEn,
    input  logic                    i_dcWrite,
    input  memBusPkg::lenT          i_dcLen,
    input  memBusPkg::addrT         i_dcAddr,
    input  memBusPkg::wordT         i_dcData,
    output logic                    o_dcDone,
    output memBusPkg::wordT         o_dcData,

    input  memBusPkg::byteT         i_memData,
    output logic [ramAddrWidth-1:0] o_memAddr,
    output logic                    o_memWrite,
    output memBusPkg::byteT         o_memData,

    input  logic                    i_stall
);
    import memBusPkg::*;

    logic latch;
    logic selData;
    logic capture;
    logic drive;
    wordT word;

    stepIf step ();

    accessSequencer sequencerInst (
        .clk       (clk),
        .rst       (rst),
        .i_ifEn    (i_ifEn),
        .i_dcEn    (i_dcEn),
        .i_dcWrite (i_dcWrite),
        .i_dcLen   (i_dcLen),
        .i_stall   (i_stall),
        .step      (step.sequencer),
        .o_latch   (latch),
        .o_selData (selData),
        .o_capture (capture),
        .o_drive   (drive),
        .o_ifDone  (o_ifDone),
        .o_dcDone  (o_dcDone)
    );

    byteCounter counterInst (
        .clk  (clk),
        .rst  (rst),
        .step (step.counter)
    );

    byteDatapath #(
        .ramAddrWidth (ramAddrWidth)
    ) datapathInst (
        .clk        (clk),
        .rst        (rst),
        .i_latch    (latch),
        .i_selData  (selData),
        .i_capture  (capture),
        .i_drive    (drive),
        .i_ifAddr   (i_ifAddr),
        .i_dcAddr   (i_dcAddr),
        .i_dcData   (i_dcData),
        .i_memData  (i_memData),
        .step       (step.datapath),
        .o_memAddr  (o_memAddr),
        .o_memWrite (o_memWrite),
        .o_memData  (o_memData),
        .o_word     (word)
    );

    // one word register serves both requesters, qualified by their done
    assign o_ifInst = word;
    assign o_dcData = word;

endmodule

// ==== memctrl/accessSequencer.sv ====
module accessSequencer (
    input  logic           clk,
    input  logic           rst,
    input  logic           i_ifEn,
    input  logic           i_dcEn,
    input  logic           i_dcWrite,
    input  memBusPkg::lenT i_dcLen,
    input  logic           i_stall,
    stepIf.sequencer       step,
    output logic           o_latch,
    output logic           o_selData,
    output logic           o_capture,
    output logic           o_drive,
    output logic           o_ifDone,
    output logic           o_dcDone
);
    import memBusPkg::*;
    import memCtrlPkg::*;

    seqStateT state;
    seqStateT nextState;
    accessKindT kind;
    accessKindT pickKind;
    logic accept;

    // only sampled in Idle, stall blocks new work
    assign accept = (state == Idle) && !i_stall && (i_ifEn || i_dcEn);

    // data side wins over a pending fetch
    always_comb begin
        if (i_dcEn) begin
            pickKind = i_dcWrite ? Store : Load;
        end else begin
            pickKind = Fetch;
        end
    end

    assign o_latch = accept;
    assign o_selData = i_dcEn;

    assign step.start = accept;
    assign step.length = i_dcEn ? i_dcLen : fetchBytes;
    assign step.advance = (state == Issue);

    assign o_drive = (state == Issue) && (kind == Store);

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (accept) begin
                    nextState = Issue;
                end
            end
            Issue: begin
                // reads need one more cycle for the last byte to return
                if (step.last) begin
                    nextState = (kind == Store) ? Done : Drain;
                end
            end
            Drain: begin
                nextState = Done;
            end
            Done: begin
                nextState = Idle;
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            kind <= Fetch;
            o_capture <= 1'b0;
            o_ifDone <= 1'b0;
            o_dcDone <= 1'b0;
        end else begin
            state <= nextState;
            // RAM answers one cycle after the address
            o_capture <= (state == Issue) && (kind != Store);
            o_ifDone <= (nextState == Done) && (kind == Fetch);
            o_dcDone <= (nextState == Done) && (kind != Fetch);
            if (accept) begin
                kind <= pickKind;
            end
        end
    end

endmodule

// ==== memctrl/byteCounter.sv ====
module byteCounter (
    input logic    clk,
    input logic    rst,
    stepIf.counter step
);
    import memBusPkg::*;

    lenT length;
    lenT lastIdx;
    byteIdxT byteIdx;

    always_ff @(posedge clk) begin
        if (rst) begin
            length <= '0;
            byteIdx <= '0;
        end else if (step.start) begin
            length <= step.length;
            byteIdx <= '0;
        end else if (step.advance) begin
            byteIdx <= byteIdx + 1'b1;
        end
    end

    assign lastIdx = length - lenT'(1);

    assign step.byteIdx = byteIdx;
    assign step.last = (lenT'(byteIdx) == lastIdx);

endmodule

// ==== memctrl/byteDatapath.sv ====
module byteDatapath #(
    parameter int ramAddrWidth = 17
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_latch,
    input  logic                    i_selData,
    input  logic                    i_capture,
    input  logic                    i_drive,
    input  memBusPkg::addrT         i_ifAddr,
    input  memBusPkg::addrT         i_dcAddr,
    input  memBusPkg::wordT         i_dcData,
    input  memBusPkg::byteT         i_memData,
    stepIf.datapath                 step,
    output logic [ramAddrWidth-1:0] o_memAddr,
    output logic                    o_memWrite,
    output memBusPkg::byteT         o_memData,
    output memBusPkg::wordT         o_word
);
    import memBusPkg::*;

    addrT baseAddr;
    addrT byteAddr;
    wordT storeWord;
    wordT loadWord;
    byteIdxT capIdx;

    always_ff @(posedge clk) begin
        if (i_latch) begin
            baseAddr <= i_selData ? i_dcAddr : i_ifAddr;
            if (i_selData) begin
                storeWord <= i_dcData;
            end
        end
        // lane of the byte now coming back from the RAM
        capIdx <= step.byteIdx;
    end

    // cleared on accept so short loads come out zero-extended
    always_ff @(posedge clk) begin
        if (rst) begin
            loadWord <= '0;
        end else if (i_latch) begin
            loadWord <= '0;
        end else if (i_capture) begin
            loadWord[byteWidth*capIdx +: byteWidth] <= i_memData;
        end
    end

    // little-endian, byte n of the word at base + n
    assign byteAddr = baseAddr + addrT'(step.byteIdx);
    assign o_memAddr = byteAddr[ramAddrWidth-1:0];

    assign o_memWrite = i_drive;
    assign o_memData = storeWord[byteWidth*step.byteIdx +: byteWidth];

    assign o_word = loadWord;

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module memCtrlTb -f build.f -o memCtrlSim \
    && ./obj_dir/memCtrlSim +verilator+error+limit+100 | tee /dev/stderr \
    | grep -qx "PASS: all tests" \
    || { echo "simulation failed" >&2; exit 1; }

// ==== tb/byteRamModel.sv ====
module byteRamModel #(
    parameter int ramAddrWidth = 17
) (
    input  logic                    clk,
    input  logic [ramAddrWidth-1:0] i_addr,
    input  logic                    i_write,
    input  memBusPkg::byteT         i_wrData,
    output memBusPkg::byteT         o_rdData
);
    timeunit 1ns;
    timeprecision 100ps;
    import memBusPkg::*;

    localparam int depth = 1 << ramAddrWidth;

    // preloaded from the testbench at time zero
    byteT mem [depth];

    always @(posedge clk) begin
        if (i_write) begin
            mem[i_addr] <= i_wrData;
        end
        // old contents on a read during write
        o_rdData <= mem[i_addr];
    end

endmodule

// ==== tb/memCtrlTb.sv ====
module memCtrlTb;
    timeunit 1ns;
    timeprecision 100ps;
    import memBusPkg::*;

    localparam int ramAddrWidth = 17;
    localparam int ramDepth = 1 << ramAddrWidth;
    localparam int randomOps = 200;
    localparam int directedOps = 24;
    localparam int doneLimit = 40;
    localparam int timeoutNs = (directedOps + randomOps) * 8 * 40 + 2000;

    typedef logic [ramAddrWidth-1:0] ramAddrT;

    logic clk, rst, stall;
    logic ifEn, ifDone, dcEn, dcWrite, dcDone, memWrite;
    addrT ifAddr, dcAddr;
    wordT ifInst, dcWrData, dcRdData;
    byteT memRdData, memWrData;
    lenT dcLen;
    ramAddrT memAddr;

    // mirror of the RAM contents
    byteT shadow [ramDepth];
    wordT ifExpQ [$];
    string ifNameQ [$];
    wordT dcExpQ [$];
    bit dcLoadQ [$];
    string dcNameQ [$];
    int errCount = 0;

    memCtrlTop #(.ramAddrWidth(ramAddrWidth)) memCtrlTop_inst (
        .clk(clk), .rst(rst), .i_stall(stall),
        .i_ifEn(ifEn), .i_ifAddr(ifAddr), .o_ifDone(ifDone), .o_ifInst(ifInst),
        .i_dcEn(dcEn), .i_dcWrite(dcWrite), .i_dcLen(dcLen), .i_dcAddr(dcAddr),
        .i_dcData(dcWrData), .o_dcDone(dcDone), .o_dcData(dcRdData),
        .i_memData(memRdData), .o_memAddr(memAddr), .o_memWrite(memWrite),
        .o_memData(memWrData)
    );

    byteRamModel #(.ramAddrWidth(ramAddrWidth)) ramInst (
        .clk(clk), .i_addr(memAddr), .i_write(memWrite), .i_wrData(memWrData),
        .o_rdData(memRdData)
    );

    // upper product bits mix in every address bit
    function automatic byteT fillByte(input logic [31:0] a);
        return byteT'((a * 32'h9E37_79B1) >> 24);
    endfunction

    // little-endian bytes at a, folded onto the RAM, zero above len
    function automatic wordT refWord(input addrT a, input lenT len);
        wordT w;
        w = '0;
        for (int i = 0; i < int'(len); i++) begin
            w[8*i +: 8] = shadow[ramAddrT'(a + addrT'(i))];
        end
        return w;
    endfunction

    task automatic checkInst(input string name, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            errCount++;
            $display("ERROR %s: fetch expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic checkLoad(input string name, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            errCount++;
            $display("ERROR %s: load expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic checkCycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            errCount++;
            $display("ERROR %s: done in cycle expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic expectData(input string name, input bit write, input lenT len,
                              input addrT a, input wordT data);
        dcNameQ.push_back(name);
        dcLoadQ.push_back(!write);
        if (write) begin
            for (int i = 0; i < int'(len); i++) begin
                shadow[ramAddrT'(a + addrT'(i))] = data[8*i +: 8];
            end
            dcExpQ.push_back('0);
        end else begin
            dcExpQ.push_back(refWord(a, len));
        end
    endtask

    // one fetch, one data request or both at once, optionally behind a stall
    task automatic request(input string name, input bit useFetch, input bit useData,
                           input bit write, input lenT len, input addrT dAddr,
                           input wordT dData, input addrT fAddr, input int stallCycles);
        int cyc;
        int dcCyc;
        int ifCyc;
        int dcLat;
        dcLat = write ? int'(len) + 1 : int'(len) + 2;
        if (useData) expectData(name, write, len, dAddr, dData);
        if (useFetch) begin
            ifNameQ.push_back(name);
            ifExpQ.push_back(refWord(fAddr, fetchBytes));
        end
        stall = (stallCycles > 0);
        dcEn = useData;
        dcWrite = write;
        dcLen = len;
        dcAddr = dAddr;
        dcWrData = dData;
        ifEn = useFetch;
        ifAddr = fAddr;
        repeat (stallCycles) begin
            @(negedge clk);
            if (ifDone || dcDone || memWrite) begin
                errCount++;
                $display("%s: done or RAM write seen while stalled", name);
            end
            @(posedge clk);
            #2;
        end
        stall = 1'b0;
        cyc = 0;
        dcCyc = -1;
        ifCyc = -1;
        while ((ifEn || dcEn) && cyc < doneLimit) begin
            @(negedge clk);
            if (dcDone) dcCyc = cyc;
            if (ifDone) ifCyc = cyc;
            @(posedge clk);
            #2;
            if (dcCyc >= 0) dcEn = 1'b0;
            if (ifCyc >= 0) ifEn = 1'b0;
            cyc++;
        end
        if (ifEn || dcEn) begin
            errCount++;
            $display("%s: no done within %0d cycles", name, doneLimit);
            ifEn = 1'b0;
            dcEn = 1'b0;
        end
        if (useData) checkCycles(name, dcLat, dcCyc);
        if (useFetch) checkCycles(name, useData ? dcLat + 7 : 6, ifCyc);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(timeoutNs);
        $display("watchdog: run still going after %0d ns, stopping", timeoutNs);
        $display("FAIL: see errors above");
        $finish;
    end

    // compare each returned word against what was queued at issue
    always @(negedge clk) begin
        if (ifDone && ifExpQ.size() == 0) begin
            errCount++;
            $display("fetch done seen with no fetch outstanding");
        end else if (ifDone) begin
            checkInst(ifNameQ.pop_front(), ifExpQ.pop_front(), ifInst);
        end
        if (dcDone && dcExpQ.size() == 0) begin
            errCount++;
            $display("data done seen with no data request outstanding");
        end else if (dcDone) begin
            if (dcLoadQ[0]) checkLoad(dcNameQ[0], dcExpQ[0], dcRdData);
            dcLoadQ.delete(0);
            dcNameQ.delete(0);
            dcExpQ.delete(0);
        end
    end

    initial begin
        int kind;
        int assertFails;
        lenT len;
        addrT a;
        void'($urandom(28));
        rst = 1'b1;
        stall = 1'b0;
        ifEn = 1'b0;
        ifAddr = '0;
        dcEn = 1'b0;
        dcWrite = 1'b0;
        dcLen = 3'd4;
        dcAddr = '0;
        dcWrData = '0;
        for (int i = 0; i < ramDepth; i++) begin
            shadow[i] = fillByte(i);
            ramInst.mem[i] = shadow[i];
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        checkLoad("after reset", '0, dcRdData);

        request("fetch aligned", 1, 0, 0, 3'd4, '0, '0, 32'h0000_0100, 0);
        request("fetch wrapping", 1, 0, 0, 3'd4, '0, '0, 32'h0001_FFFE, 0);
        request("fetch high address", 1, 0, 0, 3'd4, '0, '0, 32'hABCD_0123, 0);

        // long stores first so shorter ones leave bytes behind to check
        for (int s = 2; s >= 0; s--) begin
            len = lenT'(1 << s);
            request($sformatf("store len %0d", len), 0, 1, 1, len, 32'h0000_0301,
                    32'hA1B2_C3D4 + 32'h1111_1111 * s, '0, 0);
            for (int l = 0; l < 3; l++) begin
                request($sformatf("load len %0d after store len %0d", 1 << l, len), 0, 1, 0,
                        lenT'(1 << l), 32'h0000_0301, '0, '0, 0);
            end
        end

        request("load with fetch", 1, 1, 0, 3'd4, 32'h0000_0400, '0, 32'h0000_0500, 0);
        request("store with fetch", 1, 1, 1, 3'd2, 32'h0000_0502, 32'h0000_BEEF,
                32'h0000_0500, 0);
        request("stalled store with fetch", 1, 1, 1, 3'd4, 32'h0000_0600, 32'h1234_5678,
                32'h0000_0600, 10);

        for (int i = 0; i < randomOps; i++) begin
            kind = $urandom % 3;
            len = lenT'(1 << ($urandom % 3));
            a = ($urandom % 4 == 0) ? addrT'($urandom) : addrT'($urandom % 96);
            request($sformatf("random %0d", i), kind == 0, kind != 0, kind == 2, len, a,
                    $urandom, a, 0);
        end

        if (ifExpQ.size() != 0 || dcExpQ.size() != 0) begin
            errCount++;
            $display("requests left over with no done seen");
        end
        assertFails = memCtrlTop_inst.assertInst.failCount;
        $display("errors: %0d check, %0d assertion", errCount, assertFails);
        if (errCount == 0 && assertFails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tb/memCtrl_assertions.sv ====
module memCtrl_assertions (
    input logic           clk,
    input logic           rst,
    input logic           i_dcEn,
    input logic           i_dcWrite,
    input memBusPkg::lenT i_dcLen,
    input logic           i_ifDone,
    input logic           i_dcDone,
    input logic           i_memWrite
);
    timeunit 1ns;
    timeprecision 100ps;
    import memBusPkg::*;

    int failCount = 0;

    assert property (@(posedge clk) disable iff (rst) !(i_ifDone && i_dcDone))
    else begin
        failCount++;
        $error("fetch done and data done high in the same cycle");
    end

    // a done never stretches, and no done follows right behind another
    assert property (@(posedge clk) disable iff (rst)
        (i_ifDone || i_dcDone) |=> !(i_ifDone || i_dcDone))
    else begin
        failCount++;
        $error("done held for more than one cycle");
    end

    assert property (@(posedge clk) disable iff (rst)
        i_dcEn |-> (i_dcLen == 3'd1 || i_dcLen == 3'd2 || i_dcLen == 3'd4))
    else begin
        failCount++;
        $error("illegal data length while a data request is up");
    end

    // writes only come out of a store the requester still holds
    assert property (@(posedge clk) disable iff (rst)
        $rose(i_memWrite) |-> (i_dcEn && i_dcWrite))
    else begin
        failCount++;
        $error("RAM write started with no store in progress");
    end

endmodule

bind memCtrlTop memCtrl_assertions assertInst (
    .clk        (clk),
    .rst        (rst),
    .i_dcEn     (i_dcEn),
    .i_dcWrite  (i_dcWrite),
    .i_dcLen    (i_dcLen),
    .i_ifDone   (o_ifDone),
    .i_dcDone   (o_dcDone),
    .i_memWrite (o_memWrite)
);
